/* aligner/aligner.sv */
`timescale 1ns/1ps
`default_nettype none

module aligner #(
  parameter int vaddr_width_p = 32
) (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                redirect_i,
  input  logic                                fetch_v_i,
  input  logic [vaddr_width_p-1:0]            fetch_pc_i,
  input  logic [fe_pkg::instr_width_gp-1:0]   fetch_word_i,
  input  logic                                queue_ready_i,
  output logic                                fetch_ready_o,
  output logic                                align_v_o,
  output logic [vaddr_width_p-1:0]            align_pc_o,
  output logic [fe_pkg::instr_width_gp-1:0]   align_instr_o,
  output logic                                align_compressed_o
);

  import fe_pkg::*;

  align_state_e state_r;
  align_state_e state_n;

  // lower half of a straddling 32-bit instruction
  logic [half_width_gp-1:0] held_half_r;
  logic [vaddr_width_p-1:0] held_pc_r;

  logic [half_width_gp-1:0] lo_half;
  logic [half_width_gp-1:0] hi_half;
  logic                     lo_is_32;
  logic                     hi_is_32;
  logic [vaddr_width_p-1:0] word_pc;
  logic [vaddr_width_p-1:0] upper_pc;
  logic                     take_upper; // lower slot used, upper half still to place
  logic                     hold_upper; // upper half starts a 32-bit instr

  assign lo_half = fetch_word_i[half_width_gp-1:0];
  assign hi_half = fetch_word_i[instr_width_gp-1:half_width_gp];

  // 2'b11 in the low bits marks a full-width instruction
  assign lo_is_32 = (lo_half[1:0] == 2'b11);
  assign hi_is_32 = (hi_half[1:0] == 2'b11);

  assign word_pc  = {fetch_pc_i[vaddr_width_p-1:2], 2'b00};
  assign upper_pc = {fetch_pc_i[vaddr_width_p-1:2], 2'b10};

  always_comb begin
    state_n            = state_r;
    fetch_ready_o      = 1'b0;
    align_v_o          = 1'b0;
    align_pc_o         = word_pc;
    align_instr_o      = fetch_word_i;
    align_compressed_o = 1'b0;
    take_upper         = 1'b0;
    hold_upper         = 1'b0;

    // nothing moves without a word and room downstream
    if (fetch_v_i && queue_ready_i) begin
      case (state_r)
        ALIGN_IDLE: begin
          if (fetch_pc_i[1]) begin
            // half-word target, lower half is not ours
            if (hi_is_32) begin
              hold_upper = 1'b1;
            end else begin
              align_v_o          = 1'b1;
              align_pc_o         = upper_pc;
              align_instr_o      = {{half_width_gp{1'b0}}, hi_half};
              align_compressed_o = 1'b1;
              fetch_ready_o      = 1'b1;
            end
          end else if (lo_is_32) begin
            align_v_o     = 1'b1; // whole word is one instr
            fetch_ready_o = 1'b1;
          end else begin
            align_v_o          = 1'b1;
            align_instr_o      = {{half_width_gp{1'b0}}, lo_half};
            align_compressed_o = 1'b1;
            take_upper         = 1'b1;
          end
        end

        ALIGN_HALF_HELD: begin
          // stitch held lower half with the new word's low half
          align_v_o     = 1'b1;
          align_pc_o    = held_pc_r;
          align_instr_o = {lo_half, held_half_r};
          take_upper    = 1'b1;
        end

        ALIGN_SECOND_C: begin
          align_v_o          = 1'b1;
          align_pc_o         = upper_pc;
          align_instr_o      = {{half_width_gp{1'b0}}, hi_half};
          align_compressed_o = 1'b1;
          fetch_ready_o      = 1'b1;
          state_n            = ALIGN_IDLE;
        end

        default: begin
          state_n = ALIGN_IDLE;
        end
      endcase

      if (take_upper) begin
        if (hi_is_32) begin
          hold_upper = 1'b1;
        end else begin
          state_n = ALIGN_SECOND_C; // same word again next cycle
        end
      end

      if (hold_upper) begin
        state_n       = ALIGN_HALF_HELD;
        fetch_ready_o = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i || redirect_i) begin
      state_r <= ALIGN_IDLE;
    end else begin
      state_r <= state_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (hold_upper) begin
      held_half_r <= hi_half;
      held_pc_r   <= upper_pc;
    end
  end

endmodule : aligner

`default_nettype wire

/* common/fe_pkg.sv */
`default_nettype none

package fe_pkg;

  // fetch word and expanded instruction width
  localparam int instr_width_gp = 32;

  // compressed instruction and held half width
  localparam int half_width_gp = 16;

  typedef enum logic [1:0] {
    ALIGN_IDLE      = 2'b00, // nothing held
    ALIGN_HALF_HELD = 2'b01, // low half of a 32-bit instr waits for next word
    ALIGN_SECOND_C  = 2'b10  // upper compressed half still to go out
  } align_state_e;

  // compressed forms the expander understands
  typedef enum logic [3:0] {
    RVC_ADDI    = 4'd0, // also c.nop
    RVC_LI      = 4'd1,
    RVC_LUI     = 4'd2,
    RVC_MV      = 4'd3,
    RVC_ADD     = 4'd4,
    RVC_J       = 4'd5,
    RVC_LW      = 4'd6,
    RVC_SW      = 4'd7,
    RVC_ILLEGAL = 4'd15
  } rvc_op_e;

  // rv32 major opcodes emitted by the expander
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_JAL    = 7'b1101111
  } rv_opcode_e;

endpackage : fe_pkg

`default_nettype wire

/* flist.f */
common/fe_pkg.sv
rtl/fetch_pc_gen.sv
aligner/aligner.sv
rtl/instr_queue.sv
rtl/rvc_expander.sv
rtl/fe_align_top.sv
sim/imem_model.sv
sim/tb_fe_align.sv

/* rtl/fe_align_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fe_align_top #(
  parameter int vaddr_width_p = 32,
  parameter int fifo_depth_p  = 4,
  parameter logic [vaddr_width_p-1:0] reset_pc_p = '0
) (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                redirect_i,
  input  logic [vaddr_width_p-1:0]            redirect_pc_i,
  output logic [vaddr_width_p-1:0]            imem_addr_o,
  input  logic [fe_pkg::instr_width_gp-1:0]   imem_data_i,
  input  logic                                imem_stall_i,
  input  logic                                instr_yumi_i,
  output logic                                instr_v_o,
  output logic [fe_pkg::instr_width_gp-1:0]   instr_o,
  output logic [vaddr_width_p-1:0]            instr_pc_o,
  output logic                                instr_compressed_o,
  output logic                                instr_illegal_o
);

  import fe_pkg::*;

  // producer to aligner
  logic                      fetch_v;
  logic                      fetch_ready;
  logic [vaddr_width_p-1:0]  fetch_pc;
  logic [instr_width_gp-1:0] fetch_word;

  // aligner to queue
  logic                      align_v;
  logic                      queue_ready;
  logic [vaddr_width_p-1:0]  align_pc;
  logic [instr_width_gp-1:0] align_instr;
  logic                      align_compressed;

  // queue head to expander
  logic                      head_v;
  logic                      head_pop;
  logic [vaddr_width_p-1:0]  head_pc;
  logic [instr_width_gp-1:0] head_instr;
  logic                      head_compressed;

  fetch_pc_gen #(
    .vaddr_width_p(vaddr_width_p),
    .reset_pc_p   (reset_pc_p)
  ) pc_gen (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .redirect_i   (redirect_i),
    .redirect_pc_i(redirect_pc_i),
    .imem_stall_i (imem_stall_i),
    .imem_data_i  (imem_data_i),
    .imem_addr_o  (imem_addr_o),
    .fetch_ready_i(fetch_ready),
    .fetch_v_o    (fetch_v),
    .fetch_pc_o   (fetch_pc),
    .fetch_word_o (fetch_word)
  );

  aligner #(
    .vaddr_width_p(vaddr_width_p)
  ) align (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .redirect_i        (redirect_i),
    .fetch_v_i         (fetch_v),
    .fetch_pc_i        (fetch_pc),
    .fetch_word_i      (fetch_word),
    .queue_ready_i     (queue_ready),
    .fetch_ready_o     (fetch_ready),
    .align_v_o         (align_v),
    .align_pc_o        (align_pc),
    .align_instr_o     (align_instr),
    .align_compressed_o(align_compressed)
  );

  instr_queue #(
    .vaddr_width_p(vaddr_width_p),
    .fifo_depth_p (fifo_depth_p)
  ) queue (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .flush_i          (redirect_i), // stale instrs dropped on redirect
    .push_i           (align_v),
    .push_pc_i        (align_pc),
    .push_instr_i     (align_instr),
    .push_compressed_i(align_compressed),
    .ready_o          (queue_ready),
    .pop_i            (head_pop),
    .head_v_o         (head_v),
    .head_pc_o        (head_pc),
    .head_instr_o     (head_instr),
    .head_compressed_o(head_compressed)
  );

  rvc_expander #(
    .vaddr_width_p(vaddr_width_p)
  ) expand (
    .head_v_i          (head_v),
    .head_pc_i         (head_pc),
    .head_instr_i      (head_instr),
    .head_compressed_i (head_compressed),
    .yumi_i            (instr_yumi_i),
    .pop_o             (head_pop),
    .instr_v_o         (instr_v_o),
    .instr_o           (instr_o),
    .instr_pc_o        (instr_pc_o),
    .instr_compressed_o(instr_compressed_o),
    .instr_illegal_o   (instr_illegal_o)
  );

endmodule : fe_align_top

`default_nettype wire

/* rtl/fetch_pc_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_gen #(
  parameter int vaddr_width_p = 32,
  parameter logic [vaddr_width_p-1:0] reset_pc_p = '0
) (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                redirect_i,
  input  logic [vaddr_width_p-1:0]            redirect_pc_i,
  input  logic                                imem_stall_i,
  input  logic [fe_pkg::instr_width_gp-1:0]   imem_data_i,
  output logic [vaddr_width_p-1:0]            imem_addr_o,
  input  logic                                fetch_ready_i,
  output logic                                fetch_v_o,
  output logic [vaddr_width_p-1:0]            fetch_pc_o,
  output logic [fe_pkg::instr_width_gp-1:0]   fetch_word_o
);

  logic [vaddr_width_p-1:0] pc_r;
  logic [vaddr_width_p-1:0] word_addr;
  logic [vaddr_width_p-1:0] next_word_addr;
  logic                     fetch_accept;

  // memory is word addressed, pc may sit on a half word
  assign word_addr      = {pc_r[vaddr_width_p-1:2], 2'b00};
  assign next_word_addr = word_addr + vaddr_width_p'(4);

  assign imem_addr_o  = word_addr;
  assign fetch_word_o = imem_data_i;
  assign fetch_pc_o   = pc_r;

  // no valid fetch while a redirect is in flight
  assign fetch_v_o    = ~imem_stall_i & ~redirect_i;
  assign fetch_accept = fetch_v_o & fetch_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc_r <= reset_pc_p;
    end else if (redirect_i) begin
      pc_r <= redirect_pc_i;
    end else if (fetch_accept) begin
      pc_r <= next_word_addr; // drops the half-word offset too
    end
  end

endmodule : fetch_pc_gen

`default_nettype wire

/* rtl/instr_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_queue #(
  parameter int vaddr_width_p = 32,
  parameter int fifo_depth_p  = 4
) (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                flush_i,
  input  logic                                push_i,
  input  logic [vaddr_width_p-1:0]            push_pc_i,
  input  logic [fe_pkg::instr_width_gp-1:0]   push_instr_i,
  input  logic                                push_compressed_i,
  output logic                                ready_o,
  input  logic                                pop_i,
  output logic                                head_v_o,
  output logic [vaddr_width_p-1:0]            head_pc_o,
  output logic [fe_pkg::instr_width_gp-1:0]   head_instr_o,
  output logic                                head_compressed_o
);

  import fe_pkg::*;

  localparam int ptr_width_lp = $clog2(fifo_depth_p);
  localparam logic [ptr_width_lp:0] full_count_lp = (ptr_width_lp+1)'(fifo_depth_p);

  logic [vaddr_width_p-1:0]  pc_mem    [fifo_depth_p];
  logic [instr_width_gp-1:0] instr_mem [fifo_depth_p];
  logic                      comp_mem  [fifo_depth_p];

  logic [ptr_width_lp-1:0] wr_ptr_r;
  logic [ptr_width_lp-1:0] rd_ptr_r;
  logic [ptr_width_lp:0]   count_r;
  logic                    push_fire;
  logic                    pop_fire;

  assign ready_o   = (count_r != full_count_lp);
  assign head_v_o  = (count_r != '0);
  assign push_fire = push_i & ready_o;
  assign pop_fire  = pop_i & head_v_o;

  // head straight from storage, no bypass of a same-cycle push
  assign head_pc_o         = pc_mem[rd_ptr_r];
  assign head_instr_o      = instr_mem[rd_ptr_r];
  assign head_compressed_o = comp_mem[rd_ptr_r];

  always_ff @(posedge clk_i) begin
    if (push_fire) begin
      pc_mem[wr_ptr_r]    <= push_pc_i;
      instr_mem[wr_ptr_r] <= push_instr_i;
      comp_mem[wr_ptr_r]  <= push_compressed_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push_fire) wr_ptr_r <= wr_ptr_r + 1'b1; // power-of-two depth wraps
      if (pop_fire)  rd_ptr_r <= rd_ptr_r + 1'b1;
      case ({push_fire, pop_fire})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

endmodule : instr_queue

`default_nettype wire

/* rtl/rvc_expander.sv */
`timescale 1ns/1ps
`default_nettype none

module rvc_expander #(
  parameter int vaddr_width_p = 32
) (
  input  logic                                head_v_i,
  input  logic [vaddr_width_p-1:0]            head_pc_i,
  input  logic [fe_pkg::instr_width_gp-1:0]   head_instr_i,
  input  logic                                head_compressed_i,
  input  logic                                yumi_i,
  output logic                                pop_o,
  output logic                                instr_v_o,
  output logic [fe_pkg::instr_width_gp-1:0]   instr_o,
  output logic [vaddr_width_p-1:0]            instr_pc_o,
  output logic                                instr_compressed_o,
  output logic                                instr_illegal_o
);

  import fe_pkg::*;

  rvc_op_e op;

  logic [half_width_gp-1:0]  cinstr;
  logic [1:0]                quadrant;
  logic [2:0]                funct3;
  logic [4:0]                rd;        // full-width rd/rs1
  logic [4:0]                rs2;
  logic [4:0]                rd_p;      // 3-bit forms, x8..x15
  logic [4:0]                rs1_p;
  logic [11:0]               imm6_sext;
  logic [20:0]               j_off;
  logic [6:0]                lw_off;
  logic [instr_width_gp-1:0] expanded;

  assign cinstr   = head_instr_i[half_width_gp-1:0];
  assign quadrant = cinstr[1:0];
  assign funct3   = cinstr[15:13];
  assign rd       = cinstr[11:7];
  assign rs2      = cinstr[6:2];
  assign rd_p     = {2'b01, cinstr[4:2]};
  assign rs1_p    = {2'b01, cinstr[9:7]};

  assign imm6_sext = {{6{cinstr[12]}}, cinstr[12], cinstr[6:2]};

  // c.j offset[11|4|9:8|10|6|7|3:1|5]
  assign j_off = {{9{cinstr[12]}}, cinstr[12], cinstr[8], cinstr[10:9], cinstr[6],
                  cinstr[7], cinstr[2], cinstr[11], cinstr[5:3], 1'b0};

  // word offset for c.lw / c.sw, uimm[6:2]
  assign lw_off = {cinstr[5], cinstr[12:10], cinstr[6], 2'b00};

  always_comb begin
    op = RVC_ILLEGAL;
    case (quadrant)
      2'b00: begin
        if (funct3 == 3'b010) op = RVC_LW;
        else if (funct3 == 3'b110) op = RVC_SW;
      end
      2'b01: begin
        case (funct3)
          3'b000: op = RVC_ADDI;
          3'b010: op = RVC_LI;
          3'b011: begin
            // rd=2 is c.addi16sp, zero imm is reserved
            if (rd != 5'd0 && rd != 5'd2 && imm6_sext[5:0] != 6'd0) op = RVC_LUI;
          end
          3'b101: op = RVC_J;
          default: op = RVC_ILLEGAL;
        endcase
      end
      2'b10: begin
        // rs2 of zero means jr/jalr/ebreak, not handled
        if (funct3 == 3'b100 && rs2 != 5'd0) begin
          op = cinstr[12] ? RVC_ADD : RVC_MV;
        end
      end
      default: op = RVC_ILLEGAL;
    endcase
  end

  always_comb begin
    case (op)
      RVC_ADDI: expanded = {imm6_sext, rd, 3'b000, rd, OPC_OP_IMM};
      RVC_LI:   expanded = {imm6_sext, 5'd0, 3'b000, rd, OPC_OP_IMM};
      RVC_LUI:  expanded = {{14{cinstr[12]}}, cinstr[12], cinstr[6:2], rd, OPC_LUI};
      RVC_MV:   expanded = {7'b0, rs2, 5'd0, 3'b000, rd, OPC_OP};
      RVC_ADD:  expanded = {7'b0, rs2, rd, 3'b000, rd, OPC_OP};
      RVC_J: begin
        expanded = {j_off[20], j_off[10:1], j_off[11], j_off[19:12], 5'd0, OPC_JAL};
      end
      RVC_LW:   expanded = {5'b0, lw_off, rs1_p, 3'b010, rd_p, OPC_LOAD};
      RVC_SW: begin
        // rs2' sits where rd' is in c.lw
        expanded = {5'b0, lw_off[6:5], rd_p, rs1_p, 3'b010, lw_off[4:0], OPC_STORE};
      end
      default:  expanded = head_instr_i; // original bits kept
    endcase
  end

  assign instr_v_o          = head_v_i;
  assign instr_pc_o         = head_pc_i;
  assign instr_compressed_o = head_compressed_i;
  assign instr_illegal_o    = head_compressed_i & (op == RVC_ILLEGAL);
  assign instr_o            = head_compressed_i ? expanded : head_instr_i;
  assign pop_o              = yumi_i & head_v_i;

endmodule : rvc_expander

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module tb_fe_align

output=$(./obj_dir/Vtb_fe_align || true)
echo "$output"

if echo "$output" | grep -q -x "TESTBENCH PASSED"; then
  exit 0
fi
exit 1

/* sim/imem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module imem_model (
  input  logic        clk_i,
  input  logic        stall_en_i,
  input  logic [31:0] addr_i,
  output logic [31:0] data_o,
  output logic        stall_o
);

  // 256 words, written directly by the testbench before each test
  logic [31:0] image [256];

  integer seed = 32'h1d52_b5fd;

  initial begin
    stall_o = 1'b0;
    // power-up content, overwritten by every test
    for (int i = 0; i < 256; i++) begin
      image[i[7:0]] = {6'b0, i[7:0], 2'b01, 6'b0, i[7:0], 2'b01};
    end
  end

  assign data_o = image[addr_i[9:2]]; // combinational read, wraps at 1 KiB

  // stall level changes just after the edge, roughly one cycle in four
  always @(posedge clk_i) begin
    #1;
    stall_o = stall_en_i && (($random(seed) & 32'h3) == 0);
  end

endmodule : imem_model

`default_nettype wire

/* sim/tb_fe_align.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fe_align;

  localparam int total_instrs_lp   = 6 + 8 + 10 + 3 + 3 + 40 + 8;
  localparam int timeout_cycles_lp = total_instrs_lp * 20 + 200;

  logic        clk_i;
  logic        reset_i;
  logic        redirect_i;
  logic [31:0] redirect_pc_i;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  logic        imem_stall;
  logic        stall_en;
  logic        instr_yumi_i;
  logic        instr_v_o;
  logic [31:0] instr_o;
  logic [31:0] instr_pc_o;
  logic        instr_compressed_o;
  logic        instr_illegal_o;

  logic [15:0] hw [512]; // image as half-words, also walked by the reference
  logic [31:0] put_pc;
  logic [31:0] ref_pc;
  integer      seed = 32'h1d52_b5fd;
  int          cycles = 0;

  fe_align_top #(
    .vaddr_width_p(32),
    .fifo_depth_p (4)
  ) DUT (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .redirect_i        (redirect_i),
    .redirect_pc_i     (redirect_pc_i),
    .imem_addr_o       (imem_addr),
    .imem_data_i       (imem_data),
    .imem_stall_i      (imem_stall),
    .instr_yumi_i      (instr_yumi_i),
    .instr_v_o         (instr_v_o),
    .instr_o           (instr_o),
    .instr_pc_o        (instr_pc_o),
    .instr_compressed_o(instr_compressed_o),
    .instr_illegal_o   (instr_illegal_o)
  );

  imem_model mem (
    .clk_i     (clk_i),
    .stall_en_i(stall_en),
    .addr_i    (imem_addr),
    .data_o    (imem_data),
    .stall_o   (imem_stall)
  );

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles_lp) begin
      $display("timeout: instructions still missing after %0d cycles", cycles);
      $display("TESTBENCH FAILED");
      $fatal(1, "run stopped by timeout");
    end
  end

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %h, actual %h", what, expected, actual);
      $display("TESTBENCH FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // returns {illegal, expanded}
  function automatic logic [32:0] expand_rvc(input logic [15:0] c);
    logic [32:0] res;
    logic [31:0] simm;
    logic [31:0] off;
    logic [6:0]  uimm;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [4:0]  rdp;
    logic [4:0]  rs1p;
    res  = {1'b1, 16'b0, c}; // unsupported keeps its raw bits
    simm = {{26{c[12]}}, c[12], c[6:2]};
    rd   = c[11:7];
    rs2  = c[6:2];
    rdp  = {2'b01, c[4:2]}; // x8..x15
    rs1p = {2'b01, c[9:7]};
    uimm = {c[5], c[12:10], c[6], 2'b00};
    off     = '0;
    off[11] = c[12];
    off[4]  = c[11];
    off[9:8] = c[10:9];
    off[10] = c[8];
    off[6]  = c[7];
    off[7]  = c[6];
    off[3:1] = c[5:3];
    off[5]  = c[2];
    off     = {{20{off[11]}}, off[11:0]};
    case ({c[15:13], c[1:0]})
      5'b000_01: res = {1'b0, simm[11:0], rd, 3'b000, rd, 7'h13};
      5'b010_01: res = {1'b0, simm[11:0], 5'd0, 3'b000, rd, 7'h13};
      5'b011_01: begin
        if (rd != 5'd0 && rd != 5'd2 && simm != 0) res = {1'b0, simm[19:0], rd, 7'h37};
      end
      5'b101_01: res = {1'b0, off[20], off[10:1], off[11], off[19:12], 5'd0, 7'h6f};
      5'b010_00: res = {1'b0, 5'b0, uimm, rs1p, 3'b010, rdp, 7'h03};
      5'b110_00: res = {1'b0, 5'b0, uimm[6:5], rdp, rs1p, 3'b010, uimm[4:0], 7'h23};
      5'b100_10: begin
        if (rs2 != 5'd0) begin
          if (c[12]) res = {1'b0, 7'b0, rs2, rd, 3'b000, rd, 7'h33};
          else res = {1'b0, 7'b0, rs2, 5'd0, 3'b000, rd, 7'h33};
        end
      end
      default: res = {1'b1, 16'b0, c};
    endcase
    return res;
  endfunction

  // next instruction in program order from ref_pc
  task automatic predict_next(output logic [31:0] pc, output logic [31:0] instr,
                              output logic comp, output logic ill);
    logic [8:0]  idx;
    logic [32:0] exp;
    idx = ref_pc[9:1];
    pc  = ref_pc;
    if (hw[idx][1:0] == 2'b11) begin
      instr  = {hw[idx + 9'd1], hw[idx]};
      comp   = 1'b0;
      ill    = 1'b0;
      ref_pc = ref_pc + 32'd4;
    end else begin
      exp    = expand_rvc(hw[idx]);
      instr  = exp[31:0];
      comp   = 1'b1;
      ill    = exp[32];
      ref_pc = ref_pc + 32'd2;
    end
  endtask

  task automatic fill_nops(input logic [31:0] start);
    for (int i = 0; i < 512; i++) begin
      hw[i[8:0]] = 16'h0001; // c.nop
    end
    put_pc = start;
  endtask

  task automatic emit_half(input logic [15:0] h);
    hw[put_pc[9:1]] = h;
    put_pc = put_pc + 32'd2;
  endtask

  task automatic emit_word(input logic [31:0] w);
    hw[put_pc[9:1]] = w[15:0];
    hw[put_pc[9:1] + 9'd1] = w[31:16];
    put_pc = put_pc + 32'd4;
  endtask

  task automatic load_image();
    for (int i = 0; i < 256; i++) begin
      mem.image[i[7:0]] = {hw[{i[7:0], 1'b1}], hw[{i[7:0], 1'b0}]};
    end
  endtask

  task automatic redirect_to(input logic [31:0] pc);
    redirect_i    = 1'b1;
    redirect_pc_i = pc;
    ref_pc        = pc;
    @(posedge clk_i);
    #1;
    redirect_i = 1'b0;
  endtask

  task automatic take_instrs(input string name, input int count, input bit random_yumi);
    int          got;
    logic [31:0] r;
    logic [31:0] exp_pc;
    logic [31:0] exp_instr;
    logic        exp_comp;
    logic        exp_ill;
    got = 0;
    while (got < count) begin
      @(posedge clk_i);
      #1;
      instr_yumi_i = 1'b0;
      r = $random(seed);
      // memory address is always word aligned
      check_value({name, " imem_addr low bits"}, 32'd0, {30'b0, imem_addr[1:0]});
      if (instr_v_o && (!random_yumi || r[0])) begin
        predict_next(exp_pc, exp_instr, exp_comp, exp_ill);
        check_value({name, " pc"}, exp_pc, instr_pc_o);
        check_value({name, " instr"}, exp_instr, instr_o);
        check_value({name, " compressed"}, {31'b0, exp_comp}, {31'b0, instr_compressed_o});
        check_value({name, " illegal"}, {31'b0, exp_ill}, {31'b0, instr_illegal_o});
        instr_yumi_i = 1'b1; // pops at the next edge
        got++;
      end
    end
    @(posedge clk_i);
    #1;
    instr_yumi_i = 1'b0;
  endtask

  task automatic aligned_word_stream();
    fill_nops(32'h000);
    for (int i = 0; i < 6; i++) begin
      emit_word({12'(i + 1), 5'(i), 3'b000, 5'(i + 1), 7'h13});
    end
    load_image();
    redirect_to(32'h000);
    take_instrs("aligned_words", 6, 1'b0);
  endtask

  task automatic compressed_pair_stream();
    fill_nops(32'h080);
    emit_half(16'h0085); // c.addi x1, 1
    emit_half(16'h5175); // c.li x2, -3
    emit_half(16'h61fd); // c.lui x3, 0x1f
    emit_half(16'h8216); // c.mv x4, x5
    emit_half(16'h931e); // c.add x6, x7
    emit_half(16'h147d); // c.addi x8, -1
    load_image();
    redirect_to(32'h080);
    take_instrs("compressed_pairs", 8, 1'b0);
  endtask

  task automatic straddle_mixed_stream();
    fill_nops(32'h100);
    emit_half(16'h0085);
    emit_word(32'h00a0_0513); // straddles 0x102
    emit_word(32'h0140_0593);
    emit_half(16'h5175);
    emit_half(16'h8216);
    emit_word(32'h00b5_0633);
    emit_half(16'h147d);
    emit_word(32'hfff6_0693); // word aligned again
    load_image();
    redirect_to(32'h100);
    take_instrs("mixed_straddle", 10, 1'b0);
  endtask

  task automatic half_pc_redirects();
    fill_nops(32'h180);
    for (int i = 0; i < 8; i++) begin
      emit_word({12'(100 + i), 5'd0, 3'b000, 5'd1, 7'h13}); // stale stream
    end
    put_pc = 32'h202;
    emit_half(16'h5175);
    emit_word(32'h00a0_0513);
    put_pc = 32'h232;
    emit_word(32'h0140_0593); // crosses into 0x234
    emit_half(16'h0085);
    load_image();
    redirect_to(32'h180);
    repeat (8) @(posedge clk_i); // let the queue fill with stale entries
    #1;
    redirect_to(32'h202);
    take_instrs("redirect_half_c", 3, 1'b0);
    redirect_to(32'h232);
    take_instrs("redirect_half_32", 3, 1'b0);
  endtask

  task automatic stalled_random_stream();
    logic [31:0] r;
    logic [2:0]  kind;
    fill_nops(32'h280);
    for (int i = 0; i < 40; i++) begin
      r    = $random(seed);
      kind = r[2:0];
      r    = $random(seed);
      case (kind)
        3'd0, 3'd1: emit_word({r[31:2], 2'b11});
        3'd2: emit_half({3'b101, r[12:2], 2'b01}); // c.j
        3'd3: emit_half({3'b010, r[12:2], 2'b00}); // c.lw
        3'd4: emit_half({3'b110, r[12:2], 2'b00}); // c.sw
        3'd5: emit_half({3'b000, r[12:2], 2'b01});
        3'd6: emit_half({3'b010, r[12:2], 2'b01});
        3'd7: emit_half({3'b100, r[12:7], r[6:2] | 5'd1, 2'b10});
      endcase
    end
    load_image();
    stall_en = 1'b1;
    redirect_to(32'h280);
    take_instrs("random_stream", 40, 1'b1);
    stall_en = 1'b0;
  endtask

  task automatic illegal_rvc_stream();
    fill_nops(32'h3c0);
    emit_half(16'h0000); // all zero
    emit_half(16'h0085);
    emit_half(16'h8082); // c.jr
    emit_half(16'h4082); // c.lwsp
    emit_half(16'hc001); // c.beqz
    emit_half(16'h6105); // c.addi16sp
    emit_half(16'h6181); // c.lui with zero imm
    emit_word(32'h00a0_0513);
    load_image();
    redirect_to(32'h3c0);
    take_instrs("illegal_rvc", 8, 1'b0);
  endtask

  initial begin
    clk_i         = 1'b0;
    reset_i       = 1'b1;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    instr_yumi_i  = 1'b0;
    stall_en      = 1'b0;
    ref_pc        = '0;
    fill_nops(32'h000);
    load_image();
    repeat (16) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    check_value("reset instr_v", 32'd0, {31'b0, instr_v_o}); // queue starts empty
    aligned_word_stream();
    compressed_pair_stream();
    straddle_mixed_stream();
    half_pc_redirects();
    stalled_random_stream();
    illegal_rvc_stream();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule : tb_fe_align

`default_nettype wire
